// ==== include/dms_settings.svh ====
// ====================
// Bus widths, address map and memory layout of the dual-manager system
// Included by the package and by every file that sizes a bus or decodes an address
// ====================
`ifndef DMS_SETTINGS_SVH
`define DMS_SETTINGS_SVH

// Bus widths
`define DMS_ADDR_W 32
`define DMS_DATA_W 32

// Region select field and the two mapped regions
`define DMS_SEL_HI 31
`define DMS_SEL_LO 30
`define DMS_REGION_DATA 2'b01
`define DMS_REGION_ALU 2'b10

// Words per internal RAM
`define DMS_MEM_WORDS 256

// Byte offsets of the ALU words inside ALU memory
`define DMS_ALU_BASE 32'h8000_0000
`define DMS_ALU_CMD_OFS 32'h0
`define DMS_ALU_A_OFS 32'h4
`define DMS_ALU_B_OFS 32'h8
`define DMS_ALU_RES_OFS 32'hC

`endif

// ==== hdl/dms_pkg.sv ====
// ====================
// Shared types for the bus fabric and the ALU engine
// ====================
`include "dms_settings.svh"

package dms_pkg;

    // Bus response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } resp_t;

    // ALU opcodes, codes 8 to 15 give zero
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SLT = 4'd7
    } alu_op_e;

    // Command word layout
    typedef struct packed {
        logic [`DMS_DATA_W-5:0] rsvd;
        alu_op_e                op;
    } alu_cmd_t;

    // One ALU memory word, read as plain data or as a command
    typedef union packed {
        logic [`DMS_DATA_W-1:0] raw;
        alu_cmd_t               cmd;
    } alu_word_u;

endpackage

// ==== hdl/axi_lite_if.sv ====
`timescale 1ns/100ps
// ====================
// Single-beat AXI-lite style bus between a manager and a subordinate
// ====================
`include "dms_settings.svh"

interface axi_lite_if
    import dms_pkg::*;
();

    // Write address and data
    logic [`DMS_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`DMS_DATA_W-1:0]   wdata;
    logic [`DMS_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;

    // Write response
    resp_t                    bresp;
    logic                     bvalid;
    logic                     bready;

    // Read address and data
    logic [`DMS_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`DMS_DATA_W-1:0]   rdata;
    resp_t                    rresp;
    logic                     rvalid;
    logic                     rready;

    modport manager (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport subordinate (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// ==== hdl/alu_master.sv ====
`timescale 1ns/100ps
// ====================
// Bus-mastering ALU engine, started by a pulse
// Fetches command and operands from ALU memory and writes the result back
// ====================
`include "dms_settings.svh"

module alu_master
    import dms_pkg::*;
(
    input  logic        aclk,
    input  logic        arst_n,
    input  logic        start,
    output logic        busy,
    output logic        done,
    axi_lite_if.manager bus
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_RD_CMD = 3'd1;
    localparam logic [2:0] S_RD_A   = 3'd2;
    localparam logic [2:0] S_RD_B   = 3'd3;
    localparam logic [2:0] S_EXEC   = 3'd4;
    localparam logic [2:0] S_WR_RES = 3'd5;
    localparam logic [2:0] S_FINISH = 3'd6;

    logic [2:0]             state;
    // Address phase of the current transfer is done
    logic                   addr_sent;
    logic                   rd_state;
    logic                   ar_hs;
    logic                   r_hs;
    logic                   aw_hs;
    logic                   b_hs;
    alu_word_u              rd_word;
    alu_op_e                op;
    logic [`DMS_DATA_W-1:0] opa;
    logic [`DMS_DATA_W-1:0] opb;
    logic [`DMS_DATA_W-1:0] res;
    logic [`DMS_DATA_W-1:0] alu_y;

    assign busy = (state != S_IDLE) && (state != S_FINISH);
    assign done = (state == S_FINISH);

    // ====================
    // Bus signalling
    // ====================
    assign rd_state = (state == S_RD_CMD) || (state == S_RD_A) || (state == S_RD_B);

    assign bus.arvalid = rd_state && !addr_sent;
    assign bus.rready  = rd_state && addr_sent;
    assign bus.awvalid = (state == S_WR_RES) && !addr_sent;
    assign bus.wvalid  = (state == S_WR_RES) && !addr_sent;
    assign bus.bready  = (state == S_WR_RES) && addr_sent;
    assign bus.awaddr  = `DMS_ALU_BASE + `DMS_ALU_RES_OFS;
    assign bus.wdata   = res;
    assign bus.wstrb   = '1;

    always_comb begin
        case (state)
            S_RD_A:  bus.araddr = `DMS_ALU_BASE + `DMS_ALU_A_OFS;
            S_RD_B:  bus.araddr = `DMS_ALU_BASE + `DMS_ALU_B_OFS;
            default: bus.araddr = `DMS_ALU_BASE + `DMS_ALU_CMD_OFS;
        endcase
    end

    assign ar_hs   = bus.arvalid && bus.arready;
    assign r_hs    = bus.rvalid && bus.rready;
    assign aw_hs   = bus.awvalid && bus.awready && bus.wready;
    assign b_hs    = bus.bvalid && bus.bready;
    assign rd_word = bus.rdata;

    // ====================
    // Sequencer
    // ====================
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            addr_sent <= 1'b0;
        end else begin
            if (ar_hs || aw_hs) begin
                addr_sent <= 1'b1;
            end else if (r_hs || b_hs) begin
                addr_sent <= 1'b0;
            end
            case (state)
                S_IDLE:   if (start) state <= S_RD_CMD;
                S_RD_CMD: if (r_hs) state <= S_RD_A;
                S_RD_A:   if (r_hs) state <= S_RD_B;
                S_RD_B:   if (r_hs) state <= S_EXEC;
                S_EXEC:   state <= S_WR_RES;
                S_WR_RES: if (b_hs) state <= S_FINISH;
                // busy is already low while done shows
                default:  state <= start ? S_RD_CMD : S_IDLE;
            endcase
        end
    end

    // Command is decoded through the command view, operands pass as raw words
    always_ff @(posedge aclk) begin
        if (r_hs) begin
            case (state)
                S_RD_CMD: op <= rd_word.cmd.op;
                S_RD_A:   opa <= rd_word.raw;
                default:  opb <= rd_word.raw;
            endcase
        end
        if (state == S_EXEC) begin
            res <= alu_y;
        end
    end

    // Shift amounts use the low five bits of b
    always_comb begin
        case (op)
            OP_ADD:  alu_y = opa + opb;
            OP_SUB:  alu_y = opa - opb;
            OP_AND:  alu_y = opa & opb;
            OP_OR:   alu_y = opa | opb;
            OP_XOR:  alu_y = opa ^ opb;
            OP_SLL:  alu_y = opa << opb[4:0];
            OP_SRL:  alu_y = opa >> opb[4:0];
            OP_SLT:  alu_y = {{(`DMS_DATA_W-1){1'b0}}, $signed(opa) < $signed(opb)};
            default: alu_y = '0;
        endcase
    end

endmodule

// ==== hdl/axi_interconnect.sv ====
`timescale 1ns/100ps
// ====================
// Two-manager interconnect with round-robin grant and address bits 31:30 decode
// One transaction in flight, unmapped regions get DECERR
// ====================
`include "dms_settings.svh"

module axi_interconnect
    import dms_pkg::*;
(
    input  logic            aclk,
    input  logic            arst_n,
    axi_lite_if.subordinate mgr0,
    axi_lite_if.subordinate mgr1,
    axi_lite_if.manager     data_mem,
    axi_lite_if.manager     alu_mem
);

    // Arbitration state
    logic       own;
    logic       gnt;
    logic       last;
    logic       is_rd;
    logic [1:0] region;
    logic       req0;
    logic       req1;
    logic       pick;
    logic       pick_rd;
    logic [1:0] pick_region;
    logic       xfer_done;

    // Owner's request side
    logic [`DMS_ADDR_W-1:0]   m_awaddr;
    logic [`DMS_ADDR_W-1:0]   m_araddr;
    logic [`DMS_DATA_W-1:0]   m_wdata;
    logic [`DMS_DATA_W/8-1:0] m_wstrb;
    logic                     m_awvalid;
    logic                     m_wvalid;
    logic                     m_arvalid;
    logic                     m_bready;
    logic                     m_rready;
    logic                     awv;
    logic                     wv;
    logic                     arv;

    // Decoded subordinate's response side
    logic                     s_awready;
    logic                     s_wready;
    logic                     s_bvalid;
    logic                     s_arready;
    logic                     s_rvalid;
    resp_t                    s_bresp;
    resp_t                    s_rresp;
    logic [`DMS_DATA_W-1:0]   s_rdata;

    logic sel_data;
    logic sel_alu;
    logic sel_err;
    logic err_pend;
    logic err_awready;
    logic err_arready;

    // ====================
    // Arbiter
    // ====================
    assign req0    = mgr0.arvalid || (mgr0.awvalid && mgr0.wvalid);
    assign req1    = mgr1.arvalid || (mgr1.awvalid && mgr1.wvalid);
    // On contention the manager not served last wins
    assign pick    = (req0 && req1) ? !last : req1;
    assign pick_rd = pick ? mgr1.arvalid : mgr0.arvalid;
    assign pick_region = pick ?
        (pick_rd ? mgr1.araddr[`DMS_SEL_HI:`DMS_SEL_LO] : mgr1.awaddr[`DMS_SEL_HI:`DMS_SEL_LO]) :
        (pick_rd ? mgr0.araddr[`DMS_SEL_HI:`DMS_SEL_LO] : mgr0.awaddr[`DMS_SEL_HI:`DMS_SEL_LO]);

    assign xfer_done = own && (is_rd ? (s_rvalid && m_rready) : (s_bvalid && m_bready));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            own      <= 1'b0;
            gnt      <= 1'b0;
            last     <= 1'b1;
            is_rd    <= 1'b0;
            region   <= '0;
            err_pend <= 1'b0;
        end else begin
            if (!own && (req0 || req1)) begin
                own    <= 1'b1;
                gnt    <= pick;
                is_rd  <= pick_rd;
                region <= pick_region;
            end else if (xfer_done) begin
                own  <= 1'b0;
                last <= gnt;
            end
            if (err_awready || err_arready) begin
                err_pend <= 1'b1;
            end else if (xfer_done) begin
                err_pend <= 1'b0;
            end
        end
    end

    // ====================
    // Request routing
    // ====================
    assign m_awaddr  = gnt ? mgr1.awaddr : mgr0.awaddr;
    assign m_araddr  = gnt ? mgr1.araddr : mgr0.araddr;
    assign m_wdata   = gnt ? mgr1.wdata : mgr0.wdata;
    assign m_wstrb   = gnt ? mgr1.wstrb : mgr0.wstrb;
    assign m_awvalid = gnt ? mgr1.awvalid : mgr0.awvalid;
    assign m_wvalid  = gnt ? mgr1.wvalid : mgr0.wvalid;
    assign m_arvalid = gnt ? mgr1.arvalid : mgr0.arvalid;
    assign m_bready  = gnt ? mgr1.bready : mgr0.bready;
    assign m_rready  = gnt ? mgr1.rready : mgr0.rready;

    // Only the direction chosen at grant time is passed on
    assign awv = own && !is_rd && m_awvalid;
    assign wv  = own && !is_rd && m_wvalid;
    assign arv = own && is_rd && m_arvalid;

    assign sel_data = (region == `DMS_REGION_DATA);
    assign sel_alu  = (region == `DMS_REGION_ALU);
    assign sel_err  = !sel_data && !sel_alu;

    assign data_mem.awaddr  = m_awaddr;
    assign data_mem.wdata   = m_wdata;
    assign data_mem.wstrb   = m_wstrb;
    assign data_mem.araddr  = m_araddr;
    assign data_mem.awvalid = awv && sel_data;
    assign data_mem.wvalid  = wv && sel_data;
    assign data_mem.arvalid = arv && sel_data;
    assign data_mem.bready  = own && !is_rd && sel_data && m_bready;
    assign data_mem.rready  = own && is_rd && sel_data && m_rready;

    assign alu_mem.awaddr  = m_awaddr;
    assign alu_mem.wdata   = m_wdata;
    assign alu_mem.wstrb   = m_wstrb;
    assign alu_mem.araddr  = m_araddr;
    assign alu_mem.awvalid = awv && sel_alu;
    assign alu_mem.wvalid  = wv && sel_alu;
    assign alu_mem.arvalid = arv && sel_alu;
    assign alu_mem.bready  = own && !is_rd && sel_alu && m_bready;
    assign alu_mem.rready  = own && is_rd && sel_alu && m_rready;

    // Error responder for regions 00 and 11, answers one clock after acceptance
    assign err_awready = sel_err && awv && wv && !err_pend;
    assign err_arready = sel_err && arv && !err_pend;

    // ====================
    // Response return
    // ====================
    always_comb begin
        case (region)
            `DMS_REGION_DATA: begin
                s_awready = data_mem.awready;
                s_wready  = data_mem.wready;
                s_bvalid  = data_mem.bvalid;
                s_bresp   = data_mem.bresp;
                s_arready = data_mem.arready;
                s_rvalid  = data_mem.rvalid;
                s_rdata   = data_mem.rdata;
                s_rresp   = data_mem.rresp;
            end
            `DMS_REGION_ALU: begin
                s_awready = alu_mem.awready;
                s_wready  = alu_mem.wready;
                s_bvalid  = alu_mem.bvalid;
                s_bresp   = alu_mem.bresp;
                s_arready = alu_mem.arready;
                s_rvalid  = alu_mem.rvalid;
                s_rdata   = alu_mem.rdata;
                s_rresp   = alu_mem.rresp;
            end
            default: begin
                s_awready = err_awready;
                s_wready  = err_awready;
                s_bvalid  = err_pend && !is_rd;
                s_bresp   = DECERR;
                s_arready = err_arready;
                s_rvalid  = err_pend && is_rd;
                s_rdata   = '0;
                s_rresp   = DECERR;
            end
        endcase
    end

    assign mgr0.awready = own && !gnt && s_awready;
    assign mgr0.wready  = own && !gnt && s_wready;
    assign mgr0.bvalid  = own && !gnt && s_bvalid;
    assign mgr0.arready = own && !gnt && s_arready;
    assign mgr0.rvalid  = own && !gnt && s_rvalid;
    assign mgr0.bresp   = s_bresp;
    assign mgr0.rdata   = s_rdata;
    assign mgr0.rresp   = s_rresp;

    assign mgr1.awready = own && gnt && s_awready;
    assign mgr1.wready  = own && gnt && s_wready;
    assign mgr1.bvalid  = own && gnt && s_bvalid;
    assign mgr1.arready = own && gnt && s_arready;
    assign mgr1.rvalid  = own && gnt && s_rvalid;
    assign mgr1.bresp   = s_bresp;
    assign mgr1.rdata   = s_rdata;
    assign mgr1.rresp   = s_rresp;

endmodule

// ==== hdl/axi_ram_slave.sv ====
`timescale 1ns/100ps
// ====================
// Word RAM behind a subordinate bus port with byte strobes
// Higher address bits alias, responses hold until taken
// ====================
`include "dms_settings.svh"

module axi_ram_slave
    import dms_pkg::*;
(
    input  logic            aclk,
    input  logic            arst_n,
    axi_lite_if.subordinate bus
);

    localparam int IDX_W  = $clog2(`DMS_MEM_WORDS);
    localparam int STRB_W = `DMS_DATA_W / 8;

    logic [`DMS_DATA_W-1:0] mem [`DMS_MEM_WORDS];
    logic [`DMS_DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]       widx;
    logic [IDX_W-1:0]       ridx;
    logic                   b_pend;
    logic                   r_pend;
    logic                   pend;
    logic                   wr_acc;
    logic                   rd_acc;

    // Nothing new is taken while a response waits
    assign pend   = b_pend || r_pend;
    assign rd_acc = bus.arvalid && !pend;
    // Read wins if both directions show up together
    assign wr_acc = bus.awvalid && bus.wvalid && !pend && !bus.arvalid;

    assign bus.arready = rd_acc;
    assign bus.awready = wr_acc;
    assign bus.wready  = wr_acc;
    assign bus.bvalid  = b_pend;
    assign bus.bresp   = OKAY;
    assign bus.rvalid  = r_pend;
    assign bus.rdata   = rdata_q;
    assign bus.rresp   = OKAY;

    // Word index from bits 9:2
    assign widx = bus.awaddr[IDX_W+1:2];
    assign ridx = bus.araddr[IDX_W+1:2];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            b_pend <= 1'b0;
            r_pend <= 1'b0;
        end else begin
            if (wr_acc) begin
                b_pend <= 1'b1;
            end else if (bus.bready) begin
                b_pend <= 1'b0;
            end
            if (rd_acc) begin
                r_pend <= 1'b1;
            end else if (bus.rready) begin
                r_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_acc) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (bus.wstrb[i]) begin
                    mem[widx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
        if (rd_acc) begin
            rdata_q <= mem[ridx];
        end
    end

endmodule

// ==== hdl/dual_master_system.sv ====
`timescale 1ns/100ps
// ====================
// Top level with host port and ALU engine sharing two internal RAMs
// ====================
`include "dms_settings.svh"

module dual_master_system
    import dms_pkg::*;
(
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     alu_start,
    output logic                     alu_busy,
    output logic                     alu_done,
    // Host bus
    input  logic [`DMS_ADDR_W-1:0]   host_awaddr,
    input  logic                     host_awvalid,
    output logic                     host_awready,
    input  logic [`DMS_DATA_W-1:0]   host_wdata,
    input  logic [`DMS_DATA_W/8-1:0] host_wstrb,
    input  logic                     host_wvalid,
    output logic                     host_wready,
    output resp_t                    host_bresp,
    output logic                     host_bvalid,
    input  logic                     host_bready,
    input  logic [`DMS_ADDR_W-1:0]   host_araddr,
    input  logic                     host_arvalid,
    output logic                     host_arready,
    output logic [`DMS_DATA_W-1:0]   host_rdata,
    output resp_t                    host_rresp,
    output logic                     host_rvalid,
    input  logic                     host_rready
);

    axi_lite_if host_bus ();
    axi_lite_if alu_bus ();
    axi_lite_if data_bus ();
    axi_lite_if alu_mem_bus ();

    assign host_bus.awaddr  = host_awaddr;
    assign host_bus.awvalid = host_awvalid;
    assign host_bus.wdata   = host_wdata;
    assign host_bus.wstrb   = host_wstrb;
    assign host_bus.wvalid  = host_wvalid;
    assign host_bus.bready  = host_bready;
    assign host_bus.araddr  = host_araddr;
    assign host_bus.arvalid = host_arvalid;
    assign host_bus.rready  = host_rready;

    assign host_awready = host_bus.awready;
    assign host_wready  = host_bus.wready;
    assign host_bresp   = host_bus.bresp;
    assign host_bvalid  = host_bus.bvalid;
    assign host_arready = host_bus.arready;
    assign host_rdata   = host_bus.rdata;
    assign host_rresp   = host_bus.rresp;
    assign host_rvalid  = host_bus.rvalid;

    alu_master u_alu_master (
        .aclk   (aclk),
        .arst_n (arst_n),
        .start  (alu_start),
        .busy   (alu_busy),
        .done   (alu_done),
        .bus    (alu_bus)
    );

    // Host is manager 0, ALU engine is manager 1
    axi_interconnect u_axi_interconnect (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .mgr0     (host_bus),
        .mgr1     (alu_bus),
        .data_mem (data_bus),
        .alu_mem  (alu_mem_bus)
    );

    axi_ram_slave u_data_ram (
        .aclk   (aclk),
        .arst_n (arst_n),
        .bus    (data_bus)
    );

    axi_ram_slave u_alu_ram (
        .aclk   (aclk),
        .arst_n (arst_n),
        .bus    (alu_mem_bus)
    );

endmodule

// ==== sim/tb_dual_master_system.sv ====
`timescale 1ns/100ps
// ====================
// Directed testbench for the dual-manager system
// Drives the host port and the ALU start pin, checks every response against a model
// ====================
`include "dms_settings.svh"

module tb_dual_master_system
    import dms_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] DATA_BASE  = {`DMS_REGION_DATA, 30'h0};
    // 17 data, 4 unmapped, 36 ALU setup, 4 busy test, 12 contention
    localparam int          BUS_OPS    = 73;
    localparam int          ALU_RUNS   = 11;
    localparam int          WATCHDOG_CYCLES = (BUS_OPS + ALU_RUNS) * 50;

    logic                     aclk;
    logic                     arst_n;
    logic                     alu_start;
    logic                     alu_busy;
    logic                     alu_done;
    logic [`DMS_ADDR_W-1:0]   host_awaddr;
    logic                     host_awvalid;
    logic                     host_awready;
    logic [`DMS_DATA_W-1:0]   host_wdata;
    logic [`DMS_DATA_W/8-1:0] host_wstrb;
    logic                     host_wvalid;
    logic                     host_wready;
    resp_t                    host_bresp;
    logic                     host_bvalid;
    logic                     host_bready;
    logic [`DMS_ADDR_W-1:0]   host_araddr;
    logic                     host_arvalid;
    logic                     host_arready;
    logic [`DMS_DATA_W-1:0]   host_rdata;
    resp_t                    host_rresp;
    logic                     host_rvalid;
    logic                     host_rready;

    logic [31:0] lfsr_state = 32'h6a5d_6bb9;

    dual_master_system u_dual_master_system (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // ====================
    // Helpers
    // ====================
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_word(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Expected ALU result for a command opcode
    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return a & b;
            4'd3:    return a | b;
            4'd4:    return a ^ b;
            4'd5:    return a << b[4:0];
            4'd6:    return a >> b[4:0];
            4'd7:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
        if (got !== expected) begin
            $display("FAIL at time %0t: %s, got %h, expected %h", $time, what, got, expected);
            $display("Testbench failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Outputs are sampled at the rising edge, before the DUT registers update
    task automatic host_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output resp_t resp);
        @(negedge aclk);
        host_awaddr  = addr;
        host_wdata   = data;
        host_wstrb   = strb;
        host_awvalid = 1'b1;
        host_wvalid  = 1'b1;
        do @(posedge aclk); while (!(host_awready && host_wready));
        @(negedge aclk);
        host_awvalid = 1'b0;
        host_wvalid  = 1'b0;
        host_bready  = 1'b1;
        do @(posedge aclk); while (!host_bvalid);
        resp = host_bresp;
        @(negedge aclk);
        host_bready = 1'b0;
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data,
                             output resp_t resp);
        @(negedge aclk);
        host_araddr  = addr;
        host_arvalid = 1'b1;
        do @(posedge aclk); while (!host_arready);
        @(negedge aclk);
        host_arvalid = 1'b0;
        host_rready  = 1'b1;
        do @(posedge aclk); while (!host_rvalid);
        data = host_rdata;
        resp = host_rresp;
        @(negedge aclk);
        host_rready = 1'b0;
    endtask

    // Command word goes through the union, operands as raw words
    task automatic load_alu_job(input logic [3:0] op, input logic [31:0] a,
                                input logic [31:0] b);
        alu_word_u word;
        resp_t     resp;
        word.raw    = '0;
        word.cmd.op = alu_op_e'(op);
        host_write(`DMS_ALU_BASE + `DMS_ALU_CMD_OFS, word.raw, 4'hF, resp);
        check_eq(resp, OKAY, "ALU command write response");
        host_write(`DMS_ALU_BASE + `DMS_ALU_A_OFS, a, 4'hF, resp);
        check_eq(resp, OKAY, "ALU operand a write response");
        host_write(`DMS_ALU_BASE + `DMS_ALU_B_OFS, b, 4'hF, resp);
        check_eq(resp, OKAY, "ALU operand b write response");
    endtask

    task automatic pulse_start();
        @(negedge aclk);
        alu_start = 1'b1;
        @(negedge aclk);
        alu_start = 1'b0;
    endtask

    // Busy is still high one cycle before done and drops with it
    task automatic wait_alu_done();
        logic busy_before;
        do begin
            busy_before = alu_busy;
            @(posedge aclk);
        end while (!alu_done);
        check_eq(busy_before, 1'b1, "busy high in the cycle before done");
        check_eq(alu_busy, 1'b0, "busy low in the done cycle");
    endtask

    task automatic check_alu_result(input logic [3:0] op, input logic [31:0] a,
                                    input logic [31:0] b);
        logic [31:0] rdat;
        resp_t       resp;
        host_read(`DMS_ALU_BASE + `DMS_ALU_RES_OFS, rdat, resp);
        check_eq(resp, OKAY, "ALU result read response");
        check_eq(rdat, alu_model(op, a, b), $sformatf("ALU result for opcode %0d", op));
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic check_reset_state();
        @(posedge aclk);
        check_eq(alu_busy, 1'b0, "busy after reset");
        check_eq(alu_done, 1'b0, "done after reset");
        check_eq(host_bvalid, 1'b0, "bvalid after reset");
        check_eq(host_rvalid, 1'b0, "rvalid after reset");
    endtask

    task automatic data_memory_rw();
        logic [31:0] addr;
        logic [31:0] wdat;
        logic [31:0] rdat;
        logic [31:0] old_word;
        logic [31:0] merged;
        logic [3:0]  strb;
        resp_t       resp;
        for (int i = 0; i < 6; i++) begin
            addr = DATA_BASE | (rand_word(8) << 2);
            wdat = rand_word(32);
            host_write(addr, wdat, 4'hF, resp);
            check_eq(resp, OKAY, "data write response");
            host_read(addr, rdat, resp);
            check_eq(resp, OKAY, "data read response");
            check_eq(rdat, wdat, "data read back");
        end
        // Byte strobes merge into the old word
        addr     = DATA_BASE | 32'h20;
        old_word = rand_word(32);
        wdat     = rand_word(32);
        strb     = 4'b0101;
        host_write(addr, old_word, 4'hF, resp);
        host_write(addr, wdat, strb, resp);
        for (int n = 0; n < 4; n++) begin
            merged[8*n +: 8] = strb[n] ? wdat[8*n +: 8] : old_word[8*n +: 8];
        end
        host_read(addr, rdat, resp);
        check_eq(rdat, merged, "partial strobe merge");
        // Bit 10 is above the word index
        wdat = rand_word(32);
        host_write(DATA_BASE | 32'h44, wdat, 4'hF, resp);
        host_read(DATA_BASE | 32'h444, rdat, resp);
        check_eq(rdat, wdat, "alias 0x400 apart");
    endtask

    task automatic unmapped_decerr();
        logic [31:0] tmp;
        logic [31:0] addr;
        logic [31:0] rdat;
        resp_t       resp;
        for (int r = 0; r < 2; r++) begin
            tmp  = rand_word(28);
            addr = {(r == 0) ? 2'b00 : 2'b11, tmp[27:0], 2'b00};
            host_write(addr, rand_word(32), 4'hF, resp);
            check_eq(resp, DECERR, $sformatf("write response at %h", addr));
            host_read(addr, rdat, resp);
            check_eq(resp, DECERR, $sformatf("read response at %h", addr));
            check_eq(rdat, 32'h0, $sformatf("read data at %h", addr));
        end
    endtask

    task automatic alu_all_opcodes();
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        for (int k = 0; k < 9; k++) begin
            // Last pass uses an undefined opcode
            op = (k < 8) ? 4'(k) : 4'd11;
            a  = rand_word(32);
            b  = rand_word(32);
            load_alu_job(op, a, b);
            pulse_start();
            wait_alu_done();
            check_alu_result(op, a, b);
        end
    endtask

    task automatic start_ignored_while_busy();
        logic [31:0] a;
        logic [31:0] b;
        int          done_seen;
        a = rand_word(32);
        b = rand_word(32);
        load_alu_job(4'd4, a, b);
        pulse_start();
        @(posedge aclk);
        check_eq(alu_busy, 1'b1, "busy after start");
        pulse_start();
        wait_alu_done();
        done_seen = 1;
        repeat (50) begin
            @(posedge aclk);
            if (alu_done) begin
                done_seen++;
            end
        end
        check_eq(done_seen, 1, "done pulses for two starts");
        check_eq(alu_busy, 1'b0, "busy after the single run");
        check_alu_result(4'd4, a, b);
    endtask

    task automatic host_during_alu_run();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] vals [4];
        logic [31:0] rdat;
        resp_t       resp;
        a = rand_word(32);
        b = rand_word(32);
        for (int i = 0; i < 4; i++) begin
            vals[i] = rand_word(32);
        end
        load_alu_job(4'd1, a, b);
        pulse_start();
        fork
            wait_alu_done();
            begin
                for (int i = 0; i < 4; i++) begin
                    host_write(DATA_BASE + 32'h100 + 4 * i, vals[i], 4'hF, resp);
                    check_eq(resp, OKAY, "write response under contention");
                end
                for (int i = 0; i < 4; i++) begin
                    host_read(DATA_BASE + 32'h100 + 4 * i, rdat, resp);
                    check_eq(resp, OKAY, "read response under contention");
                    check_eq(rdat, vals[i], "read data under contention");
                end
            end
        join
        check_alu_result(4'd1, a, b);
    endtask

    // ====================
    // Main sequence and watchdog
    // ====================
    initial begin
        aclk         = 1'b0;
        arst_n       = 1'b0;
        alu_start    = 1'b0;
        host_awaddr  = '0;
        host_awvalid = 1'b0;
        host_wdata   = '0;
        host_wstrb   = '0;
        host_wvalid  = 1'b0;
        host_bready  = 1'b0;
        host_araddr  = '0;
        host_arvalid = 1'b0;
        host_rready  = 1'b0;
        repeat (5) @(negedge aclk);
        arst_n = 1'b1;
        check_reset_state();
        data_memory_rw();
        unmapped_decerr();
        alu_all_opcodes();
        start_ignored_while_busy();
        host_during_alu_run();
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== sim.f ====
+incdir+include
hdl/dms_pkg.sv
hdl/axi_lite_if.sv
hdl/alu_master.sv
hdl/axi_interconnect.sv
hdl/axi_ram_slave.sv
hdl/dual_master_system.sv
sim/tb_dual_master_system.sv

// ==== Bender.yml ====
package:
  name: dual_master_system

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dms_pkg.sv
      - hdl/axi_lite_if.sv
      - hdl/alu_master.sv
      - hdl/axi_interconnect.sv
      - hdl/axi_ram_slave.sv
      - hdl/dual_master_system.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_dual_master_system.sv
